// ==== logic/pinmux_macros.svh ====
`ifndef PINMUX_MACROS_SVH
`define PINMUX_MACROS_SVH

// Pad and bus sizes
`define PINMUX_NUM_PADS     16
`define PINMUX_APB_AW       5
`define PINMUX_APB_DW       32

// Function counts
`define PINMUX_NUM_PWM      6
`define PINMUX_NUM_INT      2

// Strap window, pads 5 to 12
`define PINMUX_STRAP_LSB    5
`define PINMUX_NUM_STRAP    8

// Input synchronizer depth
`define PINMUX_SYNC_STAGES  2

// Fixed pad positions on port D
`define PINMUX_PAD_RXD      0
`define PINMUX_PAD_TXD      1
`define PINMUX_INT_PAD_LSB  2

// PWM k pad index, packed 4 bits per entry, PWM0 in the low nibble
// PWM0..5 on PD3, PD5, PD6, PB1, PB2, PB3
`define PINMUX_PAD_IDX_W    4
`define PINMUX_PWM_PAD_MAP  {4'd11, 4'd10, 4'd9, 4'd6, 4'd5, 4'd3}

`endif

// ==== logic/pinmux_pkg.sv ====
`default_nettype none

`include "pinmux_macros.svh"

package pinmux_pkg;

  // APB register map, byte addresses
  typedef enum logic [`PINMUX_APB_AW-1:0] {
    REG_GPIO_DIR  = 5'h00,
    REG_GPIO_OUT  = 5'h04,
    REG_GPIO_IN   = 5'h08,
    REG_FUNC_SEL  = 5'h0C,
    REG_STRAP     = 5'h10
  } pinmux_reg_e;

  // Function select fields, MSB first
  typedef struct packed {
    logic                       strap_ctrl;  // 1 - strap pads held as input
    logic                       uart_enb;
    logic [`PINMUX_NUM_INT-1:0] int_enb;
    logic [`PINMUX_NUM_PWM-1:0] pwm_enb;
  } pinmux_func_t;

endpackage

`default_nettype wire

// ==== logic/pinmux_apb_regs.sv ====
`default_nettype none

`include "pinmux_macros.svh"

module pinmux_apb_regs (
  input  logic                         mclk_i,
  input  logic                         arst_n_i,
  // APB slave
  input  logic                         psel_i,
  input  logic                         penable_i,
  input  logic                         pwrite_i,
  input  logic [`PINMUX_APB_AW-1:0]    paddr_i,
  input  logic [`PINMUX_APB_DW-1:0]    pwdata_i,
  output logic [`PINMUX_APB_DW-1:0]    prdata_o,
  output logic                         pready_o,
  output logic                         pslverr_o,
  // Readback from pad side
  input  logic [`PINMUX_NUM_PADS-1:0]  gpio_in_i,
  input  logic [`PINMUX_NUM_STRAP-1:0] strap_i,
  // Configuration towards pads
  output logic [`PINMUX_NUM_PADS-1:0]  gpio_dir_o,
  output logic [`PINMUX_NUM_PADS-1:0]  gpio_out_o,
  output pinmux_pkg::pinmux_func_t     func_sel_o
);

  import pinmux_pkg::*;

  pinmux_reg_e reg_addr;
  logic        access;
  logic        addr_hit;
  logic        addr_ro;
  logic        wr_en;
  logic        rd_en;

  //----------------------------------------------------------------------
  // Address decode
  //----------------------------------------------------------------------
  assign reg_addr = pinmux_reg_e'(paddr_i);

  // Access phase, second cycle of a transfer
  assign access = psel_i & penable_i;

  always_comb begin
    addr_hit = 1'b1;
    addr_ro  = 1'b0;
    case (reg_addr)
      REG_GPIO_DIR,
      REG_GPIO_OUT,
      REG_FUNC_SEL: addr_ro = 1'b0;
      // Status only, writes rejected
      REG_GPIO_IN,
      REG_STRAP:    addr_ro = 1'b1;
      default:      addr_hit = 1'b0;
    endcase
  end

  assign wr_en = access & pwrite_i & addr_hit & ~addr_ro;
  assign rd_en = access & ~pwrite_i;

  // No wait states
  assign pready_o  = 1'b1;
  // Unmapped address or write to a status register
  assign pslverr_o = access & (~addr_hit | (pwrite_i & addr_ro));

  //----------------------------------------------------------------------
  // Writable registers
  //----------------------------------------------------------------------
  always_ff @(posedge mclk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      gpio_dir_o            <= '0;
      gpio_out_o            <= '0;
      func_sel_o            <= '0;
      // Strap pads stay input until software releases them
      func_sel_o.strap_ctrl <= 1'b1;
    end else if (wr_en) begin
      case (reg_addr)
        REG_GPIO_DIR: gpio_dir_o <= pwdata_i[`PINMUX_NUM_PADS-1:0];
        REG_GPIO_OUT: gpio_out_o <= pwdata_i[`PINMUX_NUM_PADS-1:0];
        REG_FUNC_SEL: func_sel_o <= pinmux_func_t'(pwdata_i[$bits(pinmux_func_t)-1:0]);
        default: ;
      endcase
    end
  end

  //----------------------------------------------------------------------
  // Read data, valid in the access cycle
  //----------------------------------------------------------------------
  always_comb begin
    prdata_o = '0;
    if (rd_en) begin
      case (reg_addr)
        REG_GPIO_DIR: prdata_o[`PINMUX_NUM_PADS-1:0]     = gpio_dir_o;
        REG_GPIO_OUT: prdata_o[`PINMUX_NUM_PADS-1:0]     = gpio_out_o;
        REG_GPIO_IN:  prdata_o[`PINMUX_NUM_PADS-1:0]     = gpio_in_i;
        REG_FUNC_SEL: prdata_o[$bits(pinmux_func_t)-1:0] = func_sel_o;
        REG_STRAP:    prdata_o[`PINMUX_NUM_STRAP-1:0]    = strap_i;
        default: ;
      endcase
    end
  end

  // Selected slave never stalls the master
  a_pready_on_psel: assert property (
    @(posedge mclk_i) disable iff (!arst_n_i)
    psel_i |-> pready_o
  );

  // Error only in the access phase
  a_slverr_in_access: assert property (
    @(posedge mclk_i) disable iff (!arst_n_i)
    pslverr_o |-> (psel_i && penable_i)
  );

endmodule

`default_nettype wire

// ==== logic/pinmux_pad_in.sv ====
`default_nettype none

`include "pinmux_macros.svh"

module pinmux_pad_in (
  input  logic                         mclk_i,
  input  logic                         arst_n_i,
  // Raw pad inputs
  input  logic [`PINMUX_NUM_PADS-1:0]  pad_in_i,
  // Function enables
  input  logic                         uart_enb_i,
  input  logic [`PINMUX_NUM_INT-1:0]   int_enb_i,
  // Towards registers
  output logic [`PINMUX_NUM_PADS-1:0]  gpio_in_o,
  output logic [`PINMUX_NUM_STRAP-1:0] strap_o,
  // Towards peripherals
  output logic                         uart_rxd_o,
  output logic [`PINMUX_NUM_INT-1:0]   ext_intr_o
);

  logic [`PINMUX_SYNC_STAGES-1:0][`PINMUX_NUM_PADS-1:0] sync_q;
  logic [`PINMUX_NUM_STRAP-1:0]                         strap_q;
  logic                                                 strap_vld;

  //----------------------------------------------------------------------
  // Input synchronizer with the raw pad into stage 0
  //----------------------------------------------------------------------
  always_ff @(posedge mclk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[`PINMUX_SYNC_STAGES-2:0], pad_in_i};
    end
  end

  assign gpio_in_o = sync_q[`PINMUX_SYNC_STAGES-1];

  //----------------------------------------------------------------------
  // Strap capture
  //----------------------------------------------------------------------
  // Flag set on first edge after reset release
  always_ff @(posedge mclk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      strap_vld <= 1'b0;
    end else begin
      strap_vld <= 1'b1;
    end
  end

  // Tracks the pads during reset and freezes once the flag is set
  always_ff @(posedge mclk_i) begin
    if (!strap_vld) begin
      strap_q <= pad_in_i[`PINMUX_STRAP_LSB +: `PINMUX_NUM_STRAP];
    end
  end

  assign strap_o = strap_q;

  //----------------------------------------------------------------------
  // Function routing
  //----------------------------------------------------------------------
  // Idle line high when UART0 is off
  assign uart_rxd_o = uart_enb_i ? pad_in_i[`PINMUX_PAD_RXD] : 1'b1;

  // INT0 on PD2 and INT1 on PD3 masked after sync
  assign ext_intr_o = gpio_in_o[`PINMUX_INT_PAD_LSB +: `PINMUX_NUM_INT] & int_enb_i;

  // Disabled interrupt stays quiet
  a_intr_masked: assert property (
    @(posedge mclk_i) disable iff (!arst_n_i)
    (ext_intr_o & ~int_enb_i) == '0
  );

endmodule

`default_nettype wire

// ==== logic/pinmux_pad_out.sv ====
`default_nettype none

`include "pinmux_macros.svh"

module pinmux_pad_out (
  // Register side
  input  logic [`PINMUX_NUM_PADS-1:0] gpio_dir_i,
  input  logic [`PINMUX_NUM_PADS-1:0] gpio_out_i,
  input  pinmux_pkg::pinmux_func_t    func_sel_i,
  // Peripheral outputs
  input  logic [`PINMUX_NUM_PWM-1:0]  pwm_wfm_i,
  input  logic                        uart_txd_i,
  // Pad drive with active-low oen
  output logic [`PINMUX_NUM_PADS-1:0] pad_out_o,
  output logic [`PINMUX_NUM_PADS-1:0] pad_oen_o
);

  // Pad index of each PWM in 4-bit entries
  localparam logic [`PINMUX_PAD_IDX_W*`PINMUX_NUM_PWM-1:0] pwm_pad_map = `PINMUX_PWM_PAD_MAP;

  //----------------------------------------------------------------------
  // Pad selection
  //----------------------------------------------------------------------
  // Lowest priority first so each later rule overrides
  always_comb begin
    // Default is input with output low
    pad_out_o = '0;
    pad_oen_o = '1;

    // Plain GPIO
    for (int p = 0; p < `PINMUX_NUM_PADS; p++) begin
      if (gpio_dir_i[p]) begin
        pad_oen_o[p] = 1'b0;
        pad_out_o[p] = gpio_out_i[p];
      end
    end

    // INT0/INT1 pads forced to input
    for (int k = 0; k < `PINMUX_NUM_INT; k++) begin
      if (func_sel_i.int_enb[k]) begin
        pad_oen_o[`PINMUX_INT_PAD_LSB + k] = 1'b1;
        pad_out_o[`PINMUX_INT_PAD_LSB + k] = 1'b0;
      end
    end

    // UART0 with RXD on PD0 and TXD on PD1
    if (func_sel_i.uart_enb) begin
      pad_oen_o[`PINMUX_PAD_RXD] = 1'b1;
      pad_out_o[`PINMUX_PAD_RXD] = 1'b0;
      pad_oen_o[`PINMUX_PAD_TXD] = 1'b0;
      pad_out_o[`PINMUX_PAD_TXD] = uart_txd_i;
    end

    // PWM waveforms through the pad map
    for (int k = 0; k < `PINMUX_NUM_PWM; k++) begin
      if (func_sel_i.pwm_enb[k]) begin
        pad_oen_o[pwm_pad_map[k*`PINMUX_PAD_IDX_W +: `PINMUX_PAD_IDX_W]] = 1'b0;
        pad_out_o[pwm_pad_map[k*`PINMUX_PAD_IDX_W +: `PINMUX_PAD_IDX_W]] = pwm_wfm_i[k];
      end
    end

    // Strap control wins over everything
    if (func_sel_i.strap_ctrl) begin
      for (int p = `PINMUX_STRAP_LSB; p < `PINMUX_STRAP_LSB + `PINMUX_NUM_STRAP; p++) begin
        pad_oen_o[p] = 1'b1;
        pad_out_o[p] = 1'b0;
      end
    end
  end

  //----------------------------------------------------------------------
  // Checks
  //----------------------------------------------------------------------
  // Strap window never driven under strap control
  always_comb begin
    if (func_sel_i.strap_ctrl) begin
      a_strap_input: assert final (
        pad_oen_o[`PINMUX_STRAP_LSB +: `PINMUX_NUM_STRAP] == '1
      );
    end
  end

endmodule

`default_nettype wire

// ==== logic/pinmux_top.sv ====
`default_nettype none

`include "pinmux_macros.svh"

module pinmux_top (
  input  logic                        mclk_i,
  input  logic                        arst_n_i,
  // APB slave
  input  logic                        psel_i,
  input  logic                        penable_i,
  input  logic                        pwrite_i,
  input  logic [`PINMUX_APB_AW-1:0]   paddr_i,
  input  logic [`PINMUX_APB_DW-1:0]   pwdata_i,
  output logic [`PINMUX_APB_DW-1:0]   prdata_o,
  output logic                        pready_o,
  output logic                        pslverr_o,
  // Pads
  input  logic [`PINMUX_NUM_PADS-1:0] pad_in_i,
  output logic [`PINMUX_NUM_PADS-1:0] pad_out_o,
  output logic [`PINMUX_NUM_PADS-1:0] pad_oen_o,
  // Peripherals
  input  logic [`PINMUX_NUM_PWM-1:0]  pwm_wfm_i,
  input  logic                        uart_txd_i,
  output logic                        uart_rxd_o,
  output logic [`PINMUX_NUM_INT-1:0]  ext_intr_o
);

  import pinmux_pkg::*;

  logic [`PINMUX_NUM_PADS-1:0]  gpio_dir;
  logic [`PINMUX_NUM_PADS-1:0]  gpio_out;
  logic [`PINMUX_NUM_PADS-1:0]  gpio_in;
  logic [`PINMUX_NUM_STRAP-1:0] strap;
  pinmux_func_t                 func_sel;
  logic                         uart_enb;
  logic [`PINMUX_NUM_INT-1:0]   int_enb;

  // Enables needed on the input side
  assign uart_enb = func_sel.uart_enb;
  assign int_enb  = func_sel.int_enb;

  //----------------------------------------------------------------------
  // Register block
  //----------------------------------------------------------------------
  pinmux_apb_regs i_apb_regs (
    .mclk_i     (mclk_i),
    .arst_n_i   (arst_n_i),
    .psel_i     (psel_i),
    .penable_i  (penable_i),
    .pwrite_i   (pwrite_i),
    .paddr_i    (paddr_i),
    .pwdata_i   (pwdata_i),
    .prdata_o   (prdata_o),
    .pready_o   (pready_o),
    .pslverr_o  (pslverr_o),
    .gpio_in_i  (gpio_in),
    .strap_i    (strap),
    .gpio_dir_o (gpio_dir),
    .gpio_out_o (gpio_out),
    .func_sel_o (func_sel)
  );

  // Pad inputs, strap and interrupts
  pinmux_pad_in i_pad_in (
    .mclk_i     (mclk_i),
    .arst_n_i   (arst_n_i),
    .pad_in_i   (pad_in_i),
    .uart_enb_i (uart_enb),
    .int_enb_i  (int_enb),
    .gpio_in_o  (gpio_in),
    .strap_o    (strap),
    .uart_rxd_o (uart_rxd_o),
    .ext_intr_o (ext_intr_o)
  );

  // Pad output and direction select
  pinmux_pad_out i_pad_out (
    .gpio_dir_i (gpio_dir),
    .gpio_out_i (gpio_out),
    .func_sel_i (func_sel),
    .pwm_wfm_i  (pwm_wfm_i),
    .uart_txd_i (uart_txd_i),
    .pad_out_o  (pad_out_o),
    .pad_oen_o  (pad_oen_o)
  );

endmodule

`default_nettype wire

// ==== sim/tb_pinmux_apb.svh ====
`ifndef TB_PINMUX_APB_SVH
`define TB_PINMUX_APB_SVH

  //--------------------------------------------------------------------
  // APB master, inputs change on the falling edge
  //--------------------------------------------------------------------
  // One setup and one access cycle, pready and pslverr checked in access
  task automatic apb_transfer(
    input  logic                        write,
    input  logic [`PINMUX_APB_AW-1:0]   addr,
    input  logic [`PINMUX_APB_DW-1:0]   data,
    input  logic                        exp_err,
    output logic [`PINMUX_APB_DW-1:0]   rdata
  );
    @(negedge mclk_i);
    psel_i    = 1'b1;
    penable_i = 1'b0;
    pwrite_i  = write;
    paddr_i   = addr;
    pwdata_i  = write ? data : '0;
    @(negedge mclk_i);
    penable_i = 1'b1;
    // Middle of the low phase, access cycle outputs settled
    #(CLK_PERIOD / 4);
    rdata = prdata_o;
    expect_eq("pready_o", 32'(pready_o), 32'h1);
    expect_eq("pslverr_o", 32'(pslverr_o), 32'(exp_err));
    // Register write lands on the rising edge before this
    @(negedge mclk_i);
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
  endtask

  task automatic apb_write(
    input logic [`PINMUX_APB_AW-1:0] addr,
    input logic [`PINMUX_APB_DW-1:0] data,
    input logic                      exp_err
  );
    logic [`PINMUX_APB_DW-1:0] unused_rdata;
    apb_transfer(1'b1, addr, data, exp_err, unused_rdata);
  endtask

  // Data only compared on a good read
  task automatic apb_read_check(
    input logic [`PINMUX_APB_AW-1:0] addr,
    input logic [`PINMUX_APB_DW-1:0] exp,
    input logic                      exp_err
  );
    logic [`PINMUX_APB_DW-1:0] rdata;
    apb_transfer(1'b0, addr, '0, exp_err, rdata);
    if (!exp_err) begin
      expect_eq("prdata_o", rdata, exp);
    end
  endtask

`endif

// ==== sim/tb_pinmux.sv ====
`default_nettype none

`include "pinmux_macros.svh"

module tb_pinmux;

  timeunit 1ns;
  timeprecision 100ps;

  import pinmux_pkg::*;

  localparam int CLK_PERIOD  = 8;
  localparam int RST_CYCLES  = 16;
  // Sequence runs a few hundred cycles, wide margin on top
  localparam int WDOG_CYCLES = 2000;

  logic                         mclk_i;
  logic                         arst_n_i;
  logic                         psel_i;
  logic                         penable_i;
  logic                         pwrite_i;
  logic [`PINMUX_APB_AW-1:0]    paddr_i;
  logic [`PINMUX_APB_DW-1:0]    pwdata_i;
  logic [`PINMUX_APB_DW-1:0]    prdata_o;
  logic                         pready_o;
  logic                         pslverr_o;
  logic [`PINMUX_NUM_PADS-1:0]  pad_in_i;
  logic [`PINMUX_NUM_PADS-1:0]  pad_out_o;
  logic [`PINMUX_NUM_PADS-1:0]  pad_oen_o;
  logic [`PINMUX_NUM_PWM-1:0]   pwm_wfm_i;
  logic                         uart_txd_i;
  logic                         uart_rxd_o;
  logic [`PINMUX_NUM_INT-1:0]   ext_intr_o;

  // Shadow copies of what was written
  logic [`PINMUX_APB_DW-1:0]    dir_val;
  logic [`PINMUX_APB_DW-1:0]    out_val;
  logic [`PINMUX_APB_DW-1:0]    func_val;
  logic [`PINMUX_NUM_STRAP-1:0] strap_val;

  always #(CLK_PERIOD / 2) mclk_i = ~mclk_i;

  pinmux_top i_pinmux_top (
    .mclk_i     (mclk_i),
    .arst_n_i   (arst_n_i),
    .psel_i     (psel_i),
    .penable_i  (penable_i),
    .pwrite_i   (pwrite_i),
    .paddr_i    (paddr_i),
    .pwdata_i   (pwdata_i),
    .prdata_o   (prdata_o),
    .pready_o   (pready_o),
    .pslverr_o  (pslverr_o),
    .pad_in_i   (pad_in_i),
    .pad_out_o  (pad_out_o),
    .pad_oen_o  (pad_oen_o),
    .pwm_wfm_i  (pwm_wfm_i),
    .uart_txd_i (uart_txd_i),
    .uart_rxd_o (uart_rxd_o),
    .ext_intr_o (ext_intr_o)
  );

  //--------------------------------------------------------------------
  // Failure and compare helpers
  //--------------------------------------------------------------------
  task automatic report_fail(input string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1, "Simulation stopped at first error");
  endtask

  task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
      else report_fail($sformatf("ERR %s got 0x%0h exp 0x%0h", name, got, exp));
  endtask

  // Pad state by pin priority, first matching rule wins
  function automatic void expected_pads(
    input  logic [`PINMUX_NUM_PADS-1:0] dir,
    input  logic [`PINMUX_NUM_PADS-1:0] out,
    input  logic [9:0]                  func,
    input  logic [`PINMUX_NUM_PWM-1:0]  pwm,
    input  logic                        txd,
    output logic [`PINMUX_NUM_PADS-1:0] oen,
    output logic [`PINMUX_NUM_PADS-1:0] pout
  );
    // PD3 PD5 PD6 PB1 PB2 PB3
    int pwm_pad [`PINMUX_NUM_PWM] = '{3, 5, 6, 9, 10, 11};
    int k_hit;
    oen  = '1;
    pout = '0;
    for (int p = 0; p < `PINMUX_NUM_PADS; p++) begin
      k_hit = -1;
      for (int k = 0; k < `PINMUX_NUM_PWM; k++) begin
        if (pwm_pad[k] == p && func[k]) begin
          k_hit = k;
        end
      end
      if (func[9] && p >= 5 && p <= 12) begin
        oen[p] = 1'b1;
      end else if (k_hit >= 0) begin
        oen[p]  = 1'b0;
        pout[p] = pwm[k_hit];
      end else if (func[8] && p == 1) begin
        oen[p]  = 1'b0;
        pout[p] = txd;
      end else if ((func[8] && p == 0) || (func[6] && p == 2) || (func[7] && p == 3)) begin
        oen[p] = 1'b1;
      end else if (dir[p]) begin
        oen[p]  = 1'b0;
        pout[p] = out[p];
      end
    end
  endfunction

  // Pads and UART receive against the shadow registers
  task automatic check_outputs();
    logic [`PINMUX_NUM_PADS-1:0] exp_oen;
    logic [`PINMUX_NUM_PADS-1:0] exp_out;
    logic                        exp_rxd;
    expected_pads(dir_val[15:0], out_val[15:0], func_val[9:0], pwm_wfm_i, uart_txd_i,
                  exp_oen, exp_out);
    exp_rxd = func_val[8] ? pad_in_i[0] : 1'b1;
    expect_eq("pad_oen_o", 32'(pad_oen_o), 32'(exp_oen));
    expect_eq("pad_out_o", 32'(pad_out_o), 32'(exp_out));
    expect_eq("uart_rxd_o", 32'(uart_rxd_o), 32'(exp_rxd));
  endtask

  // Toggle PD2/PD3, interrupt shows the value from two edges back
  task automatic follow_intr(input logic [1:0] en);
    logic [1:0] hist1;
    logic [1:0] hist2;
    hist1 = pad_in_i[3:2];
    hist2 = hist1;
    for (int i = 0; i < 12; i++) begin
      @(negedge mclk_i);
      expect_eq("ext_intr_o", 32'(ext_intr_o), 32'(hist2 & en));
      check_outputs();
      hist2 = hist1;
      hist1 = hist1 ^ 2'($urandom_range(3, 1));
      pad_in_i[3:2] = hist1;
    end
  endtask

`include "tb_pinmux_apb.svh"

  //--------------------------------------------------------------------
  // Protocol checks
  //--------------------------------------------------------------------
  a_tb_pready: assert property (
    @(posedge mclk_i) disable iff (!arst_n_i)
    psel_i |-> pready_o
  ) else report_fail($sformatf("ERR pready_o 0x%0h while selected", pready_o));

  a_tb_slverr_phase: assert property (
    @(posedge mclk_i) disable iff (!arst_n_i)
    pslverr_o |-> (psel_i && penable_i)
  ) else report_fail($sformatf("ERR pslverr_o 0x%0h outside access phase", pslverr_o));

  // No interrupt without the pad high two edges before
  a_tb_intr_delay: assert property (
    @(posedge mclk_i) disable iff (!arst_n_i)
    (ext_intr_o & ~$past(pad_in_i[3:2], 2)) == 2'b00
  ) else report_fail($sformatf("ERR ext_intr_o 0x%0h without earlier pad input", ext_intr_o));

  // Watchdog
  initial begin
    repeat (WDOG_CYCLES) @(posedge mclk_i);
    report_fail("Watchdog timeout, the test sequence did not finish");
  end

  //--------------------------------------------------------------------
  // Stimulus
  //--------------------------------------------------------------------
  initial begin
    void'($urandom(32'hd768_c850));
    mclk_i     = 1'b0;
    arst_n_i   = 1'b0;
    psel_i     = 1'b0;
    penable_i  = 1'b0;
    pwrite_i   = 1'b0;
    paddr_i    = '0;
    pwdata_i   = '0;
    pwm_wfm_i  = '0;
    uart_txd_i = 1'b0;
    // Strap value on pads 5 to 12 during reset
    strap_val  = 8'($urandom());
    pad_in_i   = {3'b000, strap_val, 5'b00000};
    dir_val    = '0;
    out_val    = '0;
    func_val   = 32'h0000_0200;
    repeat (RST_CYCLES) @(negedge mclk_i);
    arst_n_i = 1'b1;
    repeat (2) @(negedge mclk_i);

    // Reset state and strap capture
    check_outputs();
    expect_eq("ext_intr_o", 32'(ext_intr_o), 32'h0);
    apb_read_check(REG_STRAP, 32'(strap_val), 1'b0);

    // GPIO output with strap control released
    func_val = 32'h0;
    apb_write(REG_FUNC_SEL, func_val, 1'b0);
    dir_val = {16'h0, 16'($urandom())};
    out_val = {16'h0, 16'($urandom())};
    apb_write(REG_GPIO_DIR, dir_val, 1'b0);
    apb_write(REG_GPIO_OUT, out_val, 1'b0);
    check_outputs();

    // GPIO input, strap pads flipped but strap register frozen
    pad_in_i = {3'($urandom()), ~strap_val, 5'($urandom())};
    repeat (3) @(negedge mclk_i);
    apb_read_check(REG_GPIO_IN, 32'(pad_in_i), 1'b0);
    apb_read_check(REG_STRAP, 32'(strap_val), 1'b0);

    // All PWM plus UART0 over GPIO
    pwm_wfm_i  = 6'($urandom());
    uart_txd_i = 1'($urandom());
    func_val   = 32'h0000_013f;
    apb_write(REG_FUNC_SEL, func_val, 1'b0);
    check_outputs();
    for (int i = 0; i < 4; i++) begin
      pad_in_i[0] = ~pad_in_i[0];
      pwm_wfm_i   = 6'($urandom());
      uart_txd_i  = ~uart_txd_i;
      @(negedge mclk_i);
      check_outputs();
    end
    // Strap control back on
    func_val = 32'h0000_033f;
    apb_write(REG_FUNC_SEL, func_val, 1'b0);
    check_outputs();

    // INT0 alone, then both with PWM0 on PD3
    func_val = 32'h0000_0040;
    apb_write(REG_FUNC_SEL, func_val, 1'b0);
    follow_intr(2'b01);
    func_val = 32'h0000_00c1;
    apb_write(REG_FUNC_SEL, func_val, 1'b0);
    follow_intr(2'b11);

    // Error responses leave registers untouched
    apb_write(5'h14, 32'hffff_ffff, 1'b1);
    apb_read_check(5'h1c, 32'h0, 1'b1);
    apb_write(REG_STRAP, 32'(~strap_val), 1'b1);
    apb_write(REG_GPIO_IN, 32'hffff_ffff, 1'b1);
    apb_read_check(REG_GPIO_DIR, dir_val, 1'b0);
    apb_read_check(REG_GPIO_OUT, out_val, 1'b0);
    apb_read_check(REG_FUNC_SEL, func_val, 1'b0);
    apb_read_check(REG_STRAP, 32'(strap_val), 1'b0);
    check_outputs();

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+logic
+incdir+sim
logic/pinmux_pkg.sv
logic/pinmux_apb_regs.sv
logic/pinmux_pad_in.sv
logic/pinmux_pad_out.sv
logic/pinmux_top.sv
sim/tb_pinmux.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the pinmux testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim_run.log

verilator --binary --timing --assert --top-module tb_pinmux \
  -f compile.f --Mdir "$BUILD_DIR" -o tb_pinmux
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/tb_pinmux" > "$LOG_FILE" 2>&1
run_status=$?
cat "$LOG_FILE"
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -qF "*** TEST PASSED ***" "$LOG_FILE"; then
  exit 0
else
  echo "Pass message not found in $LOG_FILE"
  exit 1
fi
